//--- rtl/soc_pkg.sv
`default_nettype none

package soc_pkg;

	// byte address as seen on the memory bus
	typedef logic [31:0] bus_addr_t;

	// one data word on the bus
	typedef logic [31:0] bus_data_t;

	// per-byte write enables, all zero is a read
	typedef logic [3:0] byte_en_t;

	// pwm duty and its register contents
	typedef logic [7:0] duty_t;

	// region code taken from address bits 17:16
	typedef logic [1:0] region_t;

	// i/o register offset taken from address bits 4:2
	typedef logic [2:0] mmio_sel_t;

	// region map, code 11 is left unmapped and reads as zero
	localparam region_t REGION_RAM  = 2'b00;
	localparam region_t REGION_MMIO = 2'b01;
	localparam region_t REGION_ROM  = 2'b10;

	// i/o register offsets inside the mmio region
	localparam mmio_sel_t MMIO_PWM0  = 3'd0;
	localparam mmio_sel_t MMIO_PWM1  = 3'd1;
	localparam mmio_sel_t MMIO_PWM2  = 3'd2;

	// offsets 3 to 5 are free and read back zero
	localparam mmio_sel_t MMIO_TIMER = 3'd6;

endpackage

`default_nettype wire

//--- rtl/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter
	import soc_pkg::*;
(
	input  wire logic      clk,
	input  wire logic      rst,
	input  wire logic      cpu_run,

	// debug host port
	input  wire logic      dbg_mem_op,
	input  wire logic      dbg_rw,
	input  wire bus_addr_t dbg_adr,
	input  wire bus_data_t dbg_wdata,
	output logic           dbg_rdy,

	// processor instruction port
	input  wire logic      icmd_valid,
	input  wire bus_addr_t icmd_adr,
	output logic           irsp_valid,

	// processor data port
	input  wire logic      dcmd_valid,
	input  wire logic      dcmd_wr,
	input  wire byte_en_t  dcmd_mask,
	input  wire bus_addr_t dcmd_adr,
	input  wire bus_data_t dcmd_wdata,
	output logic           drsp_valid,

	// shared memory bus
	output logic           mem_op,
	output logic           mem_dbg,
	output bus_addr_t      mem_adr,
	output bus_data_t      mem_wdata,
	output byte_en_t       mem_wren
);

	logic dbg_elig;
	logic dat_elig;
	logic ins_elig;
	logic grant_dbg;
	logic grant_dat;
	logic grant_ins;

	// a port sits out the cycle of its own response pulse
	assign dbg_elig = dbg_mem_op & ~dbg_rdy;

	// processor requests only count while the cpu runs
	assign dat_elig = cpu_run & dcmd_valid & ~drsp_valid;
	assign ins_elig = cpu_run & icmd_valid & ~irsp_valid;

	// debug wins over data, data wins over instruction
	assign grant_dbg = dbg_elig;
	assign grant_dat = dat_elig & ~dbg_elig;
	assign grant_ins = ins_elig & ~dbg_elig & ~dat_elig;

	assign mem_op  = grant_dbg | grant_dat | grant_ins;
	assign mem_dbg = grant_dbg;

	// steer the winning request onto the bus
	always_comb
	begin
		mem_adr   = '0;
		mem_wdata = '0;
		mem_wren  = '0;
		if (grant_dbg)
		begin
			mem_adr   = dbg_adr;
			mem_wdata = dbg_wdata;
			// debug writes always cover the whole word
			mem_wren  = dbg_rw ? 4'b0000 : 4'b1111;
		end
		else if (grant_dat)
		begin
			mem_adr   = dcmd_adr;
			mem_wdata = dcmd_wdata;
			mem_wren  = dcmd_wr ? dcmd_mask : 4'b0000;
		end
		else if (grant_ins)
		begin
			// fetches are reads, no data and no enables
			mem_adr   = icmd_adr;
		end
	end

	// grant flags turn into the one-cycle response pulses
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			dbg_rdy    <= 1'b0;
			drsp_valid <= 1'b0;
			irsp_valid <= 1'b0;
		end
		else
		begin
			dbg_rdy    <= grant_dbg;
			drsp_valid <= grant_dat;
			irsp_valid <= grant_ins;
		end
	end

endmodule

`default_nettype wire

//--- rtl/word_ram.sv
`timescale 1ns/1ps
`default_nettype none

module word_ram
	import soc_pkg::*;
#(
	parameter int WORDS = 1024
)
(
	input  wire logic      clk,
	input  wire logic      cs,
	input  wire byte_en_t  wren,
	input  wire bus_addr_t word_adr,
	input  wire bus_data_t wdata,
	output bus_data_t      rdata
);

	localparam int AW = (WORDS > 1) ? $clog2(WORDS) : 1;

	bus_data_t mem [WORDS];
	logic [AW-1:0] idx;

	// only the low bits select a word, the region bits sit above
	assign idx = word_adr[AW-1:0];

	// byte lanes written independently
	always_ff @(posedge clk)
	begin
		for (int b = 0; b < 4; b++)
		begin
			if (cs && wren[b])
				mem[idx][b*8 +: 8] <= wdata[b*8 +: 8];
		end
	end

	// old word comes out on a write, zero when idle for the or bus
	always_ff @(posedge clk)
	begin
		if (cs)
			rdata <= mem[idx];
		else
			rdata <= '0;
	end

endmodule

`default_nettype wire

//--- rtl/pwm_channel.sv
`timescale 1ns/1ps
`default_nettype none

module pwm_channel
	import soc_pkg::*;
(
	input  wire logic  clk,
	input  wire logic  rst,
	input  wire logic  cs,
	input  wire logic  wr,
	input  wire duty_t wdata,
	output duty_t      rdata,
	output logic       wave
);

	duty_t duty;
	logic [7:0] cnt;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			duty  <= '0;
			cnt   <= '0;
			wave  <= 1'b0;
			rdata <= '0;
		end
		else
		begin
			if (cs && wr)
				duty <= wdata;
			// period of 256 clocks, wraps on its own
			cnt  <= cnt + 8'd1;
			// high for duty counts out of every 256
			wave <= (cnt < duty);
			// readback only for a selected access
			rdata <= cs ? duty : '0;
		end
	end

endmodule

`default_nettype wire

//--- rtl/us_timer.sv
`timescale 1ns/1ps
`default_nettype none

module us_timer
	import soc_pkg::*;
#(
	parameter int CLK_DIV = 16
)
(
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic cs,
	output bus_data_t rdata
);

	localparam int PW = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
	localparam logic [PW-1:0] PRE_LAST = PW'(CLK_DIV - 1);

	logic [PW-1:0] pre;
	bus_data_t usec;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pre   <= '0;
			usec  <= '0;
			rdata <= '0;
		end
		else
		begin
			// one tick every CLK_DIV clocks
			if (pre == PRE_LAST)
			begin
				pre  <= '0;
				usec <= usec + 32'd1;
			end
			else
				pre <= pre + 1'b1;
			// read only, writes just see the count
			rdata <= cs ? usec : '0;
		end
	end

endmodule

`default_nettype wire

//--- rtl/soc_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_top
	import soc_pkg::*;
#(
	parameter int RAM_WORDS = 1024,
	parameter int ROM_WORDS = 1024,
	parameter int CLK_DIV   = 16
)
(
	input  wire logic      clk,
	input  wire logic      rst,
	input  wire logic      cpu_run,

	input  wire logic      dbg_mem_op,
	input  wire logic      dbg_rw,
	input  wire bus_addr_t dbg_adr,
	input  wire bus_data_t dbg_wdata,
	output logic           dbg_rdy,

	input  wire logic      icmd_valid,
	input  wire bus_addr_t icmd_adr,
	output logic           irsp_valid,

	input  wire logic      dcmd_valid,
	input  wire logic      dcmd_wr,
	input  wire byte_en_t  dcmd_mask,
	input  wire bus_addr_t dcmd_adr,
	input  wire bus_data_t dcmd_wdata,
	output logic           drsp_valid,

	output bus_data_t      rdata,
	output logic [2:0]     pwm_out
);

	logic      mem_op;
	logic      mem_dbg;
	bus_addr_t mem_adr;
	bus_data_t mem_wdata;
	byte_en_t  mem_wren;

	region_t   region;
	mmio_sel_t mmio_off;
	bus_addr_t word_adr;
	logic      ram_sel;
	logic      rom_sel;
	logic      mmio_sel;
	logic [2:0] pwm_sel;
	logic      timer_sel;
	logic      pwm_wr;
	byte_en_t  rom_wren;

	bus_data_t ram_rdata;
	bus_data_t rom_rdata;
	bus_data_t timer_rdata;
	duty_t     pwm_rdata [3];

	bus_arbiter u_arbiter (
		.clk        (clk),
		.rst        (rst),
		.cpu_run    (cpu_run),
		.dbg_mem_op (dbg_mem_op),
		.dbg_rw     (dbg_rw),
		.dbg_adr    (dbg_adr),
		.dbg_wdata  (dbg_wdata),
		.dbg_rdy    (dbg_rdy),
		.icmd_valid (icmd_valid),
		.icmd_adr   (icmd_adr),
		.irsp_valid (irsp_valid),
		.dcmd_valid (dcmd_valid),
		.dcmd_wr    (dcmd_wr),
		.dcmd_mask  (dcmd_mask),
		.dcmd_adr   (dcmd_adr),
		.dcmd_wdata (dcmd_wdata),
		.drsp_valid (drsp_valid),
		.mem_op     (mem_op),
		.mem_dbg    (mem_dbg),
		.mem_adr    (mem_adr),
		.mem_wdata  (mem_wdata),
		.mem_wren   (mem_wren)
	);

	// address decode
	assign region   = mem_adr[17:16];
	assign mmio_off = mem_adr[4:2];
	assign word_adr = {2'b00, mem_adr[31:2]};

	assign ram_sel  = mem_op & (region == REGION_RAM);
	assign rom_sel  = mem_op & (region == REGION_ROM);
	assign mmio_sel = mem_op & (region == REGION_MMIO);

	assign pwm_sel[0] = mmio_sel & (mmio_off == MMIO_PWM0);
	assign pwm_sel[1] = mmio_sel & (mmio_off == MMIO_PWM1);
	assign pwm_sel[2] = mmio_sel & (mmio_off == MMIO_PWM2);
	assign timer_sel  = mmio_sel & (mmio_off == MMIO_TIMER);

	// any enabled byte counts as a register write
	assign pwm_wr = |mem_wren;

	// rom is writable from the debug port only
	assign rom_wren = mem_dbg ? mem_wren : 4'b0000;

	word_ram #(.WORDS(RAM_WORDS)) u_ram (
		.clk      (clk),
		.cs       (ram_sel),
		.wren     (mem_wren),
		.word_adr (word_adr),
		.wdata    (mem_wdata),
		.rdata    (ram_rdata)
	);

	word_ram #(.WORDS(ROM_WORDS)) u_rom (
		.clk      (clk),
		.cs       (rom_sel),
		.wren     (rom_wren),
		.word_adr (word_adr),
		.wdata    (mem_wdata),
		.rdata    (rom_rdata)
	);

	pwm_channel u_pwm0 (
		.clk   (clk),
		.rst   (rst),
		.cs    (pwm_sel[0]),
		.wr    (pwm_wr),
		.wdata (mem_wdata[7:0]),
		.rdata (pwm_rdata[0]),
		.wave  (pwm_out[0])
	);

	pwm_channel u_pwm1 (
		.clk   (clk),
		.rst   (rst),
		.cs    (pwm_sel[1]),
		.wr    (pwm_wr),
		.wdata (mem_wdata[7:0]),
		.rdata (pwm_rdata[1]),
		.wave  (pwm_out[1])
	);

	pwm_channel u_pwm2 (
		.clk   (clk),
		.rst   (rst),
		.cs    (pwm_sel[2]),
		.wr    (pwm_wr),
		.wdata (mem_wdata[7:0]),
		.rdata (pwm_rdata[2]),
		.wave  (pwm_out[2])
	);

	us_timer #(.CLK_DIV(CLK_DIV)) u_timer (
		.clk   (clk),
		.rst   (rst),
		.cs    (timer_sel),
		.rdata (timer_rdata)
	);

	// idle blocks return zero, so a plain or merges the read data
	assign rdata = ram_rdata | rom_rdata | timer_rdata
		| {24'b0, pwm_rdata[0]}
		| {24'b0, pwm_rdata[1]}
		| {24'b0, pwm_rdata[2]};

endmodule

`default_nettype wire

//--- testbench/tb_soc_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc_top
	import soc_pkg::*;
();

	localparam logic [1:0] P_DBG = 2'd0;
	localparam logic [1:0] P_DAT = 2'd1;
	localparam logic [1:0] P_INS = 2'd2;
	localparam int N_ENTRIES = 23;
	localparam int TIMEOUT_CYCLES = 20 * N_ENTRIES + 2000;
	localparam bus_addr_t TIMER_ADR = 32'h0001_0018;

	typedef struct packed
	{
		logic [1:0] port;
		logic       rd;
		logic       rnd;
		byte_en_t   mask;
		bus_addr_t  adr;
		bus_data_t  data;
	} entry_t;

	logic       clk;
	logic       rst;
	logic       cpu_run;
	logic       dbg_mem_op;
	logic       dbg_rw;
	bus_addr_t  dbg_adr;
	bus_data_t  dbg_wdata;
	logic       dbg_rdy;
	logic       icmd_valid;
	bus_addr_t  icmd_adr;
	logic       irsp_valid;
	logic       dcmd_valid;
	logic       dcmd_wr;
	byte_en_t   dcmd_mask;
	bus_addr_t  dcmd_adr;
	bus_data_t  dcmd_wdata;
	logic       drsp_valid;
	bus_data_t  rdata;
	logic [2:0] pwm_out;

	entry_t      stim [N_ENTRIES];
	bus_data_t   ram_model [256];
	bus_data_t   rom_model [256];
	duty_t       duty_model [3];
	logic [15:0] lfsr = 16'd64;
	int          cycle_cnt = 0;

	soc_top #(.RAM_WORDS(256), .ROM_WORDS(256), .CLK_DIV(4)) u_dut (.*);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk)
		cycle_cnt <= cycle_cnt + 1;

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1, "stopped at first error");
	endtask

	initial
	begin
		while (cycle_cnt < TIMEOUT_CYCLES)
			@(posedge clk);
		report_failure($sformatf("the run did not end within %0d cycles", TIMEOUT_CYCLES));
	end

	task automatic check_data(input string name, input bus_data_t got, input bus_data_t exp);
		if (got !== exp)
			report_failure($sformatf("Error %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_failure($sformatf("Error %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_duty(input string name, input duty_t got, input duty_t exp);
		if (got !== exp)
			report_failure($sformatf("Error %s got %h expected %h", name, got, exp));
	endtask

	// galois lfsr with taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic random_word(output bus_data_t w);
		w = '0;
		for (int i = 0; i < 32; i++)
		begin
			lfsr = lfsr_next(lfsr);
			w = {w[30:0], lfsr[0]};
		end
	endtask

	function automatic entry_t make_entry(input logic [1:0] port, input logic rd,
		input logic rnd, input byte_en_t mask, input bus_addr_t adr, input bus_data_t data);
		return {port, rd, rnd, mask, adr, data};
	endfunction

	function automatic logic resp_pulse(input logic [1:0] port);
		case (port)
			P_DBG: return dbg_rdy;
			P_DAT: return drsp_valid;
			default: return irsp_valid;
		endcase
	endfunction

	function automatic string pulse_name(input logic [1:0] port);
		case (port)
			P_DBG: return "dbg_rdy";
			P_DAT: return "drsp_valid";
			default: return "irsp_valid";
		endcase
	endfunction

	task automatic drive_port(input logic [1:0] port, input logic rd, input bus_addr_t adr,
		input bus_data_t data, input byte_en_t mask, input logic valid);
		case (port)
			P_DBG:
			begin
				dbg_mem_op = valid;
				dbg_rw     = rd;
				dbg_adr    = adr;
				dbg_wdata  = data;
			end
			P_DAT:
			begin
				dcmd_valid = valid;
				dcmd_wr    = ~rd;
				dcmd_mask  = mask;
				dcmd_adr   = adr;
				dcmd_wdata = data;
			end
			default:
			begin
				icmd_valid = valid;
				icmd_adr   = adr;
			end
		endcase
	endtask

	// uncontested access with its pulse one cycle after the request
	task automatic run_access(input logic [1:0] port, input logic rd, input bus_addr_t adr,
		input bus_data_t data, input byte_en_t mask, output bus_data_t rval, output int gcyc);
		@(posedge clk);
		#10;
		drive_port(port, rd, adr, data, mask, 1'b1);
		@(negedge clk);
		check_flag(pulse_name(port), resp_pulse(port), 1'b0);
		gcyc = cycle_cnt;
		@(negedge clk);
		check_flag(pulse_name(port), resp_pulse(port), 1'b1);
		rval = rdata;
		@(posedge clk);
		#10;
		drive_port(port, rd, adr, data, mask, 1'b0);
		@(negedge clk);
		check_flag(pulse_name(port), resp_pulse(port), 1'b0);
	endtask

	task automatic update_model(input logic [1:0] port, input bus_addr_t adr,
		input bus_data_t data, input byte_en_t mask);
		byte_en_t en;
		// debug writes cover the whole word
		en = (port == P_DBG) ? 4'hF : mask;
		for (int b = 0; b < 4; b++)
		begin
			if (en[b] && adr[17:16] == REGION_RAM)
				ram_model[adr[9:2]][b*8 +: 8] = data[b*8 +: 8];
			// rom only takes debug writes
			if (en[b] && adr[17:16] == REGION_ROM && port == P_DBG)
				rom_model[adr[9:2]][b*8 +: 8] = data[b*8 +: 8];
		end
		if (adr[17:16] == REGION_MMIO && en != 4'h0 && adr[4:2] < 3)
			duty_model[adr[4:2]] = data[7:0];
	endtask

	function automatic bus_data_t expected_word(input bus_addr_t adr);
		if (adr[17:16] == REGION_RAM)
			return ram_model[adr[9:2]];
		if (adr[17:16] == REGION_ROM)
			return rom_model[adr[9:2]];
		if (adr[17:16] == REGION_MMIO && adr[4:2] < 3)
			return {24'b0, duty_model[adr[4:2]]};
		// free offsets and region 11 read zero
		return '0;
	endfunction

	task automatic check_read(input bus_addr_t adr, input bus_data_t got);
		if (adr[17:16] == REGION_MMIO && adr[4:2] < 3)
			check_duty("rdata[7:0]", got[7:0], duty_model[adr[4:2]]);
		check_data("rdata", got, expected_word(adr));
	endtask

	initial
	begin
		entry_t    e;
		bus_data_t wdat;
		bus_data_t rval;
		bus_data_t t0;
		bus_data_t t1;
		bus_data_t prio_exp [3];
		int        c0;
		int        c1;
		int        gcyc;
		int        hi [3];

		rst = 1'b1;
		cpu_run = 1'b0;
		dbg_mem_op = 1'b0;
		dbg_rw = 1'b1;
		dbg_adr = '0;
		dbg_wdata = '0;
		icmd_valid = 1'b0;
		icmd_adr = '0;
		dcmd_valid = 1'b0;
		dcmd_wr = 1'b0;
		dcmd_mask = '0;
		dcmd_adr = '0;
		dcmd_wdata = '0;

		// port, read, random data, mask, address, data
		stim[0]  = make_entry(P_DBG, 1'b0, 1'b1, 4'hF, 32'h0000_0010, 32'h0);
		stim[1]  = make_entry(P_DBG, 1'b1, 1'b0, 4'h0, 32'h0000_0010, 32'h0);
		stim[2]  = make_entry(P_DBG, 1'b0, 1'b1, 4'hF, 32'h0002_0004, 32'h0);
		stim[3]  = make_entry(P_DBG, 1'b1, 1'b0, 4'h0, 32'h0002_0004, 32'h0);
		stim[4]  = make_entry(P_DBG, 1'b0, 1'b1, 4'hF, 32'h0000_0014, 32'h0);
		stim[5]  = make_entry(P_DBG, 1'b1, 1'b0, 4'h0, 32'h0000_0014, 32'h0);
		stim[6]  = make_entry(P_DAT, 1'b0, 1'b1, 4'h3, 32'h0000_0010, 32'h0);
		stim[7]  = make_entry(P_DAT, 1'b1, 1'b0, 4'h0, 32'h0000_0010, 32'h0);
		stim[8]  = make_entry(P_DAT, 1'b0, 1'b1, 4'h8, 32'h0000_0014, 32'h0);
		stim[9]  = make_entry(P_DAT, 1'b1, 1'b0, 4'h0, 32'h0000_0014, 32'h0);
		stim[10] = make_entry(P_DAT, 1'b0, 1'b1, 4'hF, 32'h0002_0004, 32'h0);
		stim[11] = make_entry(P_DBG, 1'b1, 1'b0, 4'h0, 32'h0002_0004, 32'h0);
		stim[12] = make_entry(P_DAT, 1'b1, 1'b0, 4'h0, 32'h0003_0008, 32'h0);
		stim[13] = make_entry(P_DBG, 1'b1, 1'b0, 4'h0, 32'h0003_0008, 32'h0);
		stim[14] = make_entry(P_INS, 1'b1, 1'b0, 4'h0, 32'h0000_0010, 32'h0);
		stim[15] = make_entry(P_DBG, 1'b0, 1'b0, 4'hF, 32'h0001_0000, 32'h0);
		stim[16] = make_entry(P_DBG, 1'b0, 1'b0, 4'hF, 32'h0001_0004, 32'h40);
		stim[17] = make_entry(P_DAT, 1'b0, 1'b0, 4'h1, 32'h0001_0008, 32'hFF);
		stim[18] = make_entry(P_DBG, 1'b1, 1'b0, 4'h0, 32'h0001_0000, 32'h0);
		stim[19] = make_entry(P_DAT, 1'b1, 1'b0, 4'h0, 32'h0001_0004, 32'h0);
		stim[20] = make_entry(P_DBG, 1'b1, 1'b0, 4'h0, 32'h0001_0008, 32'h0);
		stim[21] = make_entry(P_DBG, 1'b1, 1'b0, 4'h0, 32'h0001_000C, 32'h0);
		stim[22] = make_entry(P_DAT, 1'b1, 1'b0, 4'h0, 32'h0001_0014, 32'h0);

		repeat (4) @(posedge clk);
		#10;
		rst = 1'b0;
		cpu_run = 1'b1;

		for (int i = 0; i < N_ENTRIES; i++)
		begin
			e = stim[i];
			wdat = e.data;
			if (e.rnd)
				random_word(wdat);
			run_access(e.port, e.rd, e.adr, wdat, e.mask, rval, gcyc);
			if (e.rd)
				check_read(e.adr, rval);
			else
				update_model(e.port, e.adr, wdat, e.mask);
		end

		// all three ports request in the same cycle
		prio_exp[0] = ram_model[4];
		prio_exp[1] = ram_model[5];
		prio_exp[2] = rom_model[1];
		@(posedge clk);
		#10;
		drive_port(P_DBG, 1'b1, 32'h0000_0010, '0, '0, 1'b1);
		drive_port(P_DAT, 1'b1, 32'h0000_0014, '0, '0, 1'b1);
		drive_port(P_INS, 1'b1, 32'h0002_0004, '0, '0, 1'b1);
		@(negedge clk);
		for (int p = 0; p < 3; p++)
			check_flag(pulse_name(2'(p)), resp_pulse(2'(p)), 1'b0);
		for (int s = 0; s < 3; s++)
		begin
			@(negedge clk);
			for (int p = 0; p < 3; p++)
				check_flag(pulse_name(2'(p)), resp_pulse(2'(p)), p == s);
			check_data("rdata", rdata, prio_exp[s]);
			@(posedge clk);
			#10;
			drive_port(2'(s), 1'b1, '0, '0, '0, 1'b0);
		end
		@(negedge clk);
		for (int p = 0; p < 3; p++)
			check_flag(pulse_name(2'(p)), resp_pulse(2'(p)), 1'b0);

		// stalled data read while the cpu is held
		@(posedge clk);
		#10;
		cpu_run = 1'b0;
		drive_port(P_DAT, 1'b1, 32'h0000_0014, '0, '0, 1'b1);
		repeat (20)
		begin
			@(negedge clk);
			check_flag("drsp_valid", drsp_valid, 1'b0);
		end
		@(posedge clk);
		#10;
		cpu_run = 1'b1;
		@(negedge clk);
		check_flag("drsp_valid", drsp_valid, 1'b0);
		@(negedge clk);
		check_flag("drsp_valid", drsp_valid, 1'b1);
		check_data("rdata", rdata, ram_model[5]);
		@(posedge clk);
		#10;
		drive_port(P_DAT, 1'b1, '0, '0, '0, 1'b0);

		// one full pwm period
		hi = '{0, 0, 0};
		repeat (256)
		begin
			@(negedge clk);
			for (int b = 0; b < 3; b++)
				hi[b] += pwm_out[b];
		end
		for (int b = 0; b < 3; b++)
			check_data($sformatf("pwm_out[%0d] high cycles", b), bus_data_t'(hi[b]),
				{24'b0, duty_model[b]});

		run_access(P_DBG, 1'b1, TIMER_ADR, '0, '0, t0, c0);
		repeat (40) @(posedge clk);
		run_access(P_DBG, 1'b1, TIMER_ADR, '0, '0, t1, c1);
		// four clocks per count at CLK_DIV 4 with one count of slack
		if (int'(t1 - t0) > (c1 - c0) / 4 + 1 || int'(t1 - t0) + 1 < (c1 - c0) / 4)
			report_failure($sformatf("timer moved %0d counts over %0d cycles",
				int'(t1 - t0), c1 - c0));
		else
		begin
			$display("Finished with no errors");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- sim.f
rtl/soc_pkg.sv
rtl/bus_arbiter.sv
rtl/word_ram.sv
rtl/pwm_channel.sv
rtl/us_timer.sv
rtl/soc_top.sv
testbench/tb_soc_top.sv
